// ==== logic/div_ctrl.sv ====
/*
  divider control fsm: accepts one request, runs the step phase until
  the counter flags the last step, then holds the response until taken
*/
`timescale 1ns/10ps
`default_nettype none

module div_ctrl (
  input  logic clk,
  input  logic reset,

  // request and response handshake
  input  logic divreq_val,
  input  logic divresp_rdy,

  // from the step counter
  input  logic last_step,

  output logic divreq_rdy,
  output logic divresp_val,

  // strobes to the datapath and counter
  output logic load,
  output logic step
);

  div_pkg::div_state_t state;
  div_pkg::div_state_t state_next;

  // transfer on an edge where both sides agree
  logic req_xfer;
  logic resp_xfer;

  assign req_xfer  = divreq_val && divreq_rdy;
  assign resp_xfer = divresp_val && divresp_rdy;

  // ----------------------------------------------------------------------
  // state register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::idle: begin
        // operands are loaded on this same edge
        if (req_xfer) begin
          state_next = div_pkg::calc;
        end
      end
      div_pkg::calc: begin
        // the last step still runs on the edge that leaves calc
        if (last_step) begin
          state_next = div_pkg::done;
        end
      end
      div_pkg::done: begin
        // result held here until the consumer takes it
        if (resp_xfer) begin
          state_next = div_pkg::idle;
        end
      end
      default: begin
        state_next = div_pkg::idle;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // outputs, decoded from state only
  // ----------------------------------------------------------------------

  // rdy never looks at val
  assign divreq_rdy  = (state == div_pkg::idle);
  assign divresp_val = (state == div_pkg::done);

  // load only in the cycle a request is taken
  assign load = req_xfer;

  // one shift-subtract per cycle in calc
  assign step = (state == div_pkg::calc);

endmodule

`default_nettype wire

// ==== logic/div_pkg.sv ====
/*
  shared widths, function codes, vector types and the controller state
  type for the iterative divider; referenced by scoped name only
*/
`default_nettype none

package div_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // operand, quotient and remainder width, fixed by the isa
  localparam int data_width = 32;

  // one restoring step per quotient bit
  localparam int step_count = 32;

  // ----------------------------------------------------------------------
  // request function codes
  // ----------------------------------------------------------------------

  localparam logic fn_unsigned = 1'b0;
  localparam logic fn_signed   = 1'b1;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------

  // operands, magnitudes, quotient and remainder
  typedef logic [data_width-1:0] word_t;

  // response layout: remainder in the upper half, quotient in the lower
  typedef logic [2*data_width-1:0] result_t;

  // accumulator and aligned divisor, top bit is the borrow
  typedef logic [2*data_width:0] acc_t;

  // counts the steps still to run
  typedef logic [$clog2(step_count)-1:0] step_cnt_t;

  // handshake fsm
  typedef enum logic [1:0] {
    idle,
    calc,
    done
  } div_state_t;

endpackage

`default_nettype wire

// ==== logic/div_restoring_core.sv ====
/*
  unsigned restoring divider datapath, one shift-subtract step per clock
  while step is high; results are read once stepping has stopped
*/
`timescale 1ns/10ps
`default_nettype none

module div_restoring_core (
  input  logic           clk,
  input  logic           reset,
  input  logic           load,
  input  logic           step,

  // operand magnitudes, sampled on load
  input  div_pkg::word_t mag_a,
  input  div_pkg::word_t mag_b,

  output div_pkg::word_t quot_mag,
  output div_pkg::word_t rem_mag
);

  // ----------------------------------------------------------------------
  // step datapath
  // ----------------------------------------------------------------------

  // partial remainder in the upper part, quotient bits enter at bit 0
  div_pkg::acc_t acc;

  // divisor aligned to the upper half, bit 64 stays clear
  div_pkg::acc_t divisor;

  div_pkg::acc_t acc_shift;
  div_pkg::acc_t acc_diff;
  logic          borrow;

  assign acc_shift = acc << 1;
  assign acc_diff  = acc_shift - divisor;

  // top bit set means the shifted remainder was below the divisor
  assign borrow = acc_diff[2*div_pkg::data_width];

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc     <= '0;
      divisor <= '0;
    end else if (load) begin
      // dividend zero-extended into the low half
      acc     <= div_pkg::acc_t'(mag_a);
      divisor <= {1'b0, mag_b, div_pkg::word_t'(0)};
    end else if (step) begin
      if (borrow) begin
        // restore, quotient bit 0 already shifted in
        acc <= acc_shift;
      end else begin
        // keep the difference and set the quotient bit
        acc <= {acc_diff[2*div_pkg::data_width:1], 1'b1};
      end
    end
  end

  // ----------------------------------------------------------------------
  // results
  // ----------------------------------------------------------------------

  // after the last step the dividend bits have all been replaced by
  // quotient bits and the remainder sits just above them
  assign quot_mag = acc[div_pkg::data_width-1:0];
  assign rem_mag  = acc[2*div_pkg::data_width-1:div_pkg::data_width];

endmodule

`default_nettype wire

// ==== logic/div_sign_unit.sv ====
/*
  sign handling around the unsigned core: hands magnitudes in at load,
  keeps the operand signs, and corrects quotient and remainder on the way out
*/
`timescale 1ns/10ps
`default_nettype none

module div_sign_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,

  // request message
  input  logic             divreq_fn,
  input  div_pkg::word_t   divreq_a,
  input  div_pkg::word_t   divreq_b,

  // unsigned results from the core
  input  div_pkg::word_t   quot_mag,
  input  div_pkg::word_t   rem_mag,

  // operand magnitudes to the core
  output div_pkg::word_t   mag_a,
  output div_pkg::word_t   mag_b,

  output div_pkg::result_t divresp_result
);

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------

  logic req_signed;
  logic req_neg_a;
  logic req_neg_b;

  assign req_signed = (divreq_fn == div_pkg::fn_signed);

  // an operand counts as negative only for a signed request
  assign req_neg_a = req_signed && divreq_a[div_pkg::data_width-1];
  assign req_neg_b = req_signed && divreq_b[div_pkg::data_width-1];

  // two's complement negate, the most negative value maps onto itself
  // and still reads correctly as an unsigned magnitude
  assign mag_a = req_neg_a ? (~divreq_a + 1'b1) : divreq_a;
  assign mag_b = req_neg_b ? (~divreq_b + 1'b1) : divreq_b;

  // ----------------------------------------------------------------------
  // captured request info
  // ----------------------------------------------------------------------

  logic fn_reg;
  logic sign_a_reg;
  logic sign_b_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= div_pkg::fn_unsigned;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      fn_reg     <= divreq_fn;
      sign_a_reg <= divreq_a[div_pkg::data_width-1];
      sign_b_reg <= divreq_b[div_pkg::data_width-1];
    end
  end

  // ----------------------------------------------------------------------
  // output side
  // ----------------------------------------------------------------------

  logic           quot_neg;
  logic           rem_neg;
  div_pkg::word_t quot_out;
  div_pkg::word_t rem_out;

  // quotient goes negative when the operand signs differ
  assign quot_neg = (fn_reg == div_pkg::fn_signed) && (sign_a_reg ^ sign_b_reg);

  // remainder takes the dividend's sign
  assign rem_neg  = (fn_reg == div_pkg::fn_signed) && sign_a_reg;

  assign quot_out = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg  ? (~rem_mag + 1'b1)  : rem_mag;

  // remainder high, quotient low
  assign divresp_result = {rem_out, quot_out};

endmodule

`default_nettype wire

// ==== logic/div_step_counter.sv ====
/*
  counts the shift-subtract steps of one division and flags the last one
*/
`timescale 1ns/10ps
`default_nettype none

module div_step_counter (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last_step
);

  div_pkg::step_cnt_t count;

  // preset to steps minus one so that zero marks the final step
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= div_pkg::step_cnt_t'(div_pkg::step_count - 1);
    end else if (step) begin
      // wraps after the last step, ignored once out of calc
      count <= count - 1'b1;
    end
  end

  // count of zero means the current step is the last
  assign last_step = (count == '0);

endmodule

`default_nettype wire

// ==== logic/int_div_iterative.sv ====
/*
  iterative 32-bit divider with val/rdy request and response ports;
  one division in flight, response 32 cycles after the request is taken
*/
`timescale 1ns/10ps
`default_nettype none

module int_div_iterative (
  input  logic             clk,
  input  logic             reset,

  // request: function bit, dividend, divisor
  input  logic             divreq_fn,
  input  div_pkg::word_t   divreq_a,
  input  div_pkg::word_t   divreq_b,
  input  logic             divreq_val,
  output logic             divreq_rdy,

  // response: remainder high, quotient low
  output div_pkg::result_t divresp_result,
  output logic             divresp_val,
  input  logic             divresp_rdy
);

  // ----------------------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------------------

  // control strobes
  logic load;
  logic step;
  logic last_step;

  // magnitudes in and out of the core
  div_pkg::word_t mag_a;
  div_pkg::word_t mag_b;
  div_pkg::word_t quot_mag;
  div_pkg::word_t rem_mag;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------

  div_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divresp_rdy (divresp_rdy),
    .last_step   (last_step),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .load        (load),
    .step        (step)
  );

  div_step_counter i_counter (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .last_step (last_step)
  );

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  div_sign_unit i_sign (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .quot_mag       (quot_mag),
    .rem_mag        (rem_mag),
    .mag_a          (mag_a),
    .mag_b          (mag_b),
    .divresp_result (divresp_result)
  );

  div_restoring_core i_core (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the divider testbench with verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module div_tb -f src.f -o div_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/div_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== src.f ====
logic/div_pkg.sv
logic/div_ctrl.sv
logic/div_step_counter.sv
logic/div_sign_unit.sv
logic/div_restoring_core.sv
logic/int_div_iterative.sv
testbench/div_tb.sv

// ==== testbench/div_tb.sv ====
/*
  testbench for the iterative divider with directed and random divisions checked
  against a reference model plus handshake, latency and stall checks
*/
`timescale 1ns/10ps
`default_nettype none

module div_tb;

  // generous bound for every wait loop
  localparam int wait_limit = 64;

  logic             clk;
  logic             reset;
  logic             divreq_fn;
  div_pkg::word_t   divreq_a;
  div_pkg::word_t   divreq_b;
  logic             divreq_val;
  logic             divreq_rdy;
  div_pkg::result_t divresp_result;
  logic             divresp_val;
  logic             divresp_rdy;

  integer seed;

  // one entry per division together with its response stall length
  logic           req_fn[$];
  div_pkg::word_t req_a[$];
  div_pkg::word_t req_b[$];
  int             req_hold[$];

  int_div_iterative i_dut (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // remainder high and quotient low with the quotient truncated toward zero
  function automatic div_pkg::result_t ref_div(input logic fn, input div_pkg::word_t a,
                                               input div_pkg::word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] q;
    logic signed [63:0] r;
    logic signed [63:0] qmag;
    if (fn == div_pkg::fn_signed) begin
      sa = {{32{a[31]}}, a};
      sb = {{32{b[31]}}, b};
    end else begin
      sa = {32'h0, a};
      sb = {32'h0, b};
    end
    qmag = 64'sh0000_0000_ffff_ffff;
    if (sb == 0) begin
      // all ones quotient magnitude and the dividend itself as remainder
      q = (sa < 0) ? -qmag : qmag;
      r = sa;
    end else if ((fn == div_pkg::fn_signed) && (a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
      q = 64'sh0000_0000_8000_0000;
      r = 64'sh0;
    end else begin
      q = sa / sb;
      r = sa % sb;
    end
    return {r[31:0], q[31:0]};
  endfunction

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------

  task automatic add_request(input logic fn, input div_pkg::word_t a, input div_pkg::word_t b);
    div_pkg::word_t r;
    r = $random(seed);
    req_fn.push_back(fn);
    req_a.push_back(a);
    req_b.push_back(b);
    req_hold.push_back(int'(r[2:0]));
  endtask

  task automatic build_requests();
    int             i;
    div_pkg::word_t am;
    div_pkg::word_t bm;
    div_pkg::word_t sh;
    // directed unsigned cases including a divisor above the dividend
    add_request(div_pkg::fn_unsigned, 32'd100, 32'd7);
    add_request(div_pkg::fn_unsigned, 32'hffff_ffff, 32'd1);
    add_request(div_pkg::fn_unsigned, 32'h8000_0000, 32'd3);
    add_request(div_pkg::fn_unsigned, 32'd5, 32'hffff_fff0);
    add_request(div_pkg::fn_unsigned, 32'd0, 32'd5);
    // directed signed cases over all sign pairs
    add_request(div_pkg::fn_signed, -32'd100, 32'd7);
    add_request(div_pkg::fn_signed, 32'd100, -32'd7);
    add_request(div_pkg::fn_signed, -32'd100, -32'd7);
    add_request(div_pkg::fn_signed, 32'd7, 32'd100);
    // divide by zero and overflow corners
    add_request(div_pkg::fn_unsigned, 32'h1234_5678, 32'd0);
    add_request(div_pkg::fn_unsigned, 32'hf000_0001, 32'd0);
    add_request(div_pkg::fn_signed, -32'd20, 32'd0);
    add_request(div_pkg::fn_signed, 32'd20, 32'd0);
    add_request(div_pkg::fn_signed, 32'h8000_0000, 32'hffff_ffff);
    add_request(div_pkg::fn_signed, 32'h8000_0000, 32'd1);
    // random unsigned with the top bit set in every other dividend
    for (i = 0; i < 20; i++) begin
      am = $random(seed);
      bm = $random(seed);
      sh = $random(seed);
      am[31] = i[0];
      if (i % 5 == 0) begin
        // small dividend so the divisor is larger
        am = am >> 16;
      end
      add_request(div_pkg::fn_unsigned, am, bm >> sh[4:0]);
    end
    // random signed cycling through the four sign combinations
    for (i = 0; i < 24; i++) begin
      am = $random(seed);
      bm = $random(seed);
      sh = $random(seed);
      am[31] = 1'b0;
      bm = bm >> (sh[4:0] | 5'd1);
      add_request(div_pkg::fn_signed, i[1] ? -am : am, i[0] ? -bm : bm);
    end
  endtask

  // drive at a falling edge
  task automatic present_request(input int idx);
    divreq_fn  = req_fn[idx];
    divreq_a   = req_a[idx];
    divreq_b   = req_b[idx];
    divreq_val = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // checks sampled at a rising edge
  // ----------------------------------------------------------------------

  task automatic check_response(input div_pkg::result_t expected);
    assert (divresp_val)
      else stop_with_error($sformatf("Error: divresp_val expected 0x1 got 0x%h", divresp_val));
    assert (divresp_result == expected)
      else stop_with_error($sformatf("Error: divresp_result expected 0x%h got 0x%h",
                                     expected, divresp_result));
    // a waiting request must not be taken while the response is pending
    assert (!divreq_rdy)
      else stop_with_error($sformatf("Error: divreq_rdy expected 0x0 got 0x%h", divreq_rdy));
  endtask

  task automatic complete_division(input int idx);
    div_pkg::result_t expected;
    int               waited;
    int               edges;
    int               c;
    expected = ref_div(req_fn[idx], req_a[idx], req_b[idx]);
    // request already on the bus so wait for the accepting edge
    waited = 0;
    @(posedge clk);
    while (!divreq_rdy) begin
      waited++;
      if (waited > wait_limit) begin
        stop_with_error("Timeout waiting for the request to be accepted");
      end
      @(posedge clk);
    end
    // back to back requests are taken on the first edge they are offered
    assert (waited == 0)
      else stop_with_error("Request was not accepted on the first edge it was offered");
    @(negedge clk);
    divreq_val = 1'b0;
    // operands are free to change once taken
    divreq_a   = $random(seed);
    divreq_b   = $random(seed);
    divreq_fn  = ~divreq_fn;
    // count the edges before the response appears
    edges = 0;
    @(posedge clk);
    while (!divresp_val) begin
      assert (!divreq_rdy)
        else stop_with_error($sformatf("Error: divreq_rdy expected 0x0 got 0x%h", divreq_rdy));
      edges++;
      if (edges > wait_limit) begin
        stop_with_error("Timeout waiting for divresp_val after the request was accepted");
      end
      @(posedge clk);
    end
    // one edge per quotient bit of a 32-bit division
    assert (edges == 32)
      else stop_with_error($sformatf("Error: divresp_val latency expected 0x%h got 0x%h",
                                     32, edges));
    check_response(expected);
    // stall the response with the next request already waiting
    @(negedge clk);
    if (idx + 1 < req_fn.size()) begin
      present_request(idx + 1);
    end
    for (c = 0; c < req_hold[idx]; c++) begin
      @(posedge clk);
      check_response(expected);
      @(negedge clk);
    end
    divresp_rdy = 1'b1;
    // response transfer edge
    @(posedge clk);
    check_response(expected);
    @(negedge clk);
    divresp_rdy = 1'b0;
  endtask

  // stalled response must hold its value while rdy and val never overlap
  logic             stall_seen;
  div_pkg::result_t stall_result;

  always @(posedge clk) begin
    if (reset) begin
      stall_seen = 1'b0;
    end else begin
      if (stall_seen) begin
        assert (divresp_val)
          else stop_with_error($sformatf("Error: divresp_val expected 0x1 got 0x%h",
                                         divresp_val));
        assert (divresp_result == stall_result)
          else stop_with_error($sformatf("Error: divresp_result expected 0x%h got 0x%h",
                                         stall_result, divresp_result));
      end
      assert (!(divreq_rdy && divresp_val))
        else stop_with_error("divreq_rdy and divresp_val were high in the same cycle");
      stall_seen   = divresp_val && !divresp_rdy;
      stall_result = divresp_result;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    int idx;
    seed        = 32'hc651;
    clk         = 1'b0;
    reset       = 1'b1;
    divreq_fn   = 1'b0;
    divreq_a    = '0;
    divreq_b    = '0;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b0;
    build_requests();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    // idle after reset
    assert (divreq_rdy)
      else stop_with_error($sformatf("Error: divreq_rdy expected 0x1 got 0x%h", divreq_rdy));
    assert (!divresp_val)
      else stop_with_error($sformatf("Error: divresp_val expected 0x0 got 0x%h", divresp_val));
    @(negedge clk);
    present_request(0);
    for (idx = 0; idx < req_fn.size(); idx++) begin
      complete_division(idx);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
